//--- verilog/core_defines.svh
// ---------------------------------------
// Core-wide widths and reset vector
// Register count must be 2**REG_IDX_W
// ---------------------------------------
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define XLEN 32

`define REG_COUNT 32

`define REG_IDX_W 5

`define RESET_PC 32'h8000_0000  // First fetch address

`endif

//--- verilog/isa_pkg.sv
// ---------------------------------------
// RV32I encodings for the kept opcodes only
// ---------------------------------------
package isa_pkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N  // Unknown, retires as no-op
    } inst_fmt_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // Same word seen as R and I layout
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

//--- verilog/core_pkg.sv
// ---------------------------------------
// Micro-architecture types of the core
// ---------------------------------------
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        REQUEST,
        WAIT,   // Instruction fetch outstanding
        EXECUTE
    } fetch_state_e;

endpackage

//--- verilog/decode_if.sv
// ---------------------------------------
// Decoded fields, valid only in EXECUTE
// ---------------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

interface decode_if import isa_pkg::*, core_pkg::*; ();
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      imm;
    inst_fmt_e             fmt;
    logic [6:0]            opcode;  // Raw, may be unknown
    logic [2:0]            funct3;
    alu_op_e               alu_op;
    logic                  jalr;

    modport decoder (output rs1, rs2, rd, imm, fmt, opcode, funct3, alu_op, jalr);

    modport consumer (input rs1, rs2, rd, imm, fmt, opcode, funct3, alu_op, jalr);
endinterface

//--- verilog/fetch_unit.sv
// ---------------------------------------
// One fetch outstanding, no back-pressure
// First request one cycle after reset ends
// ---------------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_unit import isa_pkg::*, core_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    output logic             imem_req,
    output logic [`XLEN-1:0] imem_addr,
    input  logic             imem_valid,
    input  logic [`XLEN-1:0] imem_rdata,
    input  logic [`XLEN-1:0] next_pc,
    output inst_u            inst,
    output logic [`XLEN-1:0] pc,
    output logic             exec
);
    fetch_state_e state;
    logic         started;  // Low while reset is held

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= REQUEST;
            started <= 1'b0;
            pc      <= `RESET_PC;
        end else begin
            started <= 1'b1;
            case (state)
                REQUEST: if (started) state <= WAIT;
                WAIT:    if (imem_valid) state <= EXECUTE;
                EXECUTE: begin
                    state <= REQUEST;
                    pc    <= next_pc;  // Retire point
                end
                default: state <= REQUEST;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT && imem_valid)
            inst <= imem_rdata;
    end

    assign imem_req  = (state == REQUEST) && started;
    assign imem_addr = pc;
    assign exec      = (state == EXECUTE);

    // Memory must not answer outside a pending fetch
    a_valid_in_wait: assert property (@(posedge clk) disable iff (reset)
        imem_valid |-> state == WAIT);

    a_req_single: assert property (@(posedge clk) disable iff (reset)
        imem_req |=> !imem_req);

endmodule

//--- verilog/inst_decoder.sv
// ---------------------------------------
// Combinational RV32I decode
// ---------------------------------------
`timescale 1ns/1ps

module inst_decoder import isa_pkg::*, core_pkg::*; (
    input inst_u      inst,
    decode_if.decoder dec
);
    logic [6:0] funct7;

    assign funct7     = inst.r.funct7;
    assign dec.rs1    = inst.r.rs1;
    assign dec.rs2    = inst.r.rs2;
    assign dec.rd     = inst.r.rd;
    assign dec.opcode = inst.r.opcode;
    assign dec.funct3 = inst.r.funct3;
    assign dec.jalr   = (inst.r.opcode == JALR);

    always_comb begin
        case (inst.r.opcode)
            OP:            dec.fmt = FMT_R;
            OP_IMM, JALR:  dec.fmt = FMT_I;
            BRANCH:        dec.fmt = FMT_B;
            LUI, AUIPC:    dec.fmt = FMT_U;
            JAL:           dec.fmt = FMT_J;
            default:       dec.fmt = FMT_N;
        endcase
    end

    // B, U and J immediates are scattered over the R fields
    always_comb begin
        case (dec.fmt)
            FMT_I: dec.imm = {{20{inst.i.imm12[11]}}, inst.i.imm12};
            FMT_B: dec.imm = {{20{funct7[6]}}, inst.r.rd[0], funct7[5:0], inst.r.rd[4:1], 1'b0};
            FMT_U: dec.imm = {funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
            FMT_J: dec.imm = {{12{funct7[6]}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                              funct7[5:0], inst.r.rs2[4:1], 1'b0};
            default: dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.alu_op = ALU_ADD;  // Address math for jumps and AUIPC
        if (dec.fmt == FMT_R || inst.r.opcode == OP_IMM) begin
            case (inst.r.funct3)
                3'b000: dec.alu_op = (dec.fmt == FMT_R && funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: dec.alu_op = ALU_SLL;
                3'b010: dec.alu_op = ALU_SLT;
                3'b011: dec.alu_op = ALU_SLTU;
                3'b100: dec.alu_op = ALU_XOR;
                3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end
    end

endmodule

//--- verilog/reg_file.sv
// ---------------------------------------
// x0 reads zero, writes to it are dropped
// ---------------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    decode_if.consumer            dec,
    input  logic                  wr_en,
    input  logic [`REG_IDX_W-1:0] wr_idx,
    input  logic [`XLEN-1:0]      wr_data,
    output logic [`XLEN-1:0]      rs1_data,
    output logic [`XLEN-1:0]      rs2_data
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // One write per retired instruction
    a_single_write: assert property (@(posedge clk) disable iff (reset)
        wr_en |=> !wr_en);

endmodule

//--- verilog/execute_unit.sv
// ---------------------------------------
// Pure combinational, results used in EXECUTE
// ---------------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_unit import isa_pkg::*, core_pkg::*; (
    decode_if.consumer            dec,
    input  logic                  exec,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      rs2_data,
    output logic [`XLEN-1:0]      next_pc,
    output logic                  wr_en,
    output logic [`REG_IDX_W-1:0] wr_idx,
    output logic [`XLEN-1:0]      wr_data
);
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] pc_plus4;
    logic [4:0]       shamt;
    logic             taken;
    logic             wr_flag;

    always_comb begin
        case (dec.fmt)
            FMT_R:        begin alu_a = rs1_data; alu_b = rs2_data; end
            FMT_I:        begin alu_a = rs1_data; alu_b = dec.imm; end
            FMT_U:        begin alu_a = (dec.opcode == LUI) ? '0 : pc; alu_b = dec.imm; end
            FMT_J, FMT_B: begin alu_a = pc; alu_b = dec.imm; end
            default:      begin alu_a = '0; alu_b = '0; end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_res = alu_a - alu_b;
            ALU_SLL:  alu_res = alu_a << shamt;
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:  alu_res = alu_a ^ alu_b;
            ALU_SRL:  alu_res = alu_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(alu_a) >>> shamt);
            ALU_OR:   alu_res = alu_a | alu_b;
            ALU_AND:  alu_res = alu_a & alu_b;
            default:  alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 4;

    always_comb begin
        next_pc = pc_plus4;
        wr_data = alu_res;
        wr_flag = 1'b0;
        case (dec.fmt)
            FMT_R, FMT_U: wr_flag = 1'b1;
            FMT_I: begin
                wr_flag = 1'b1;
                if (dec.jalr) begin
                    next_pc = {alu_res[`XLEN-1:1], 1'b0};
                    wr_data = pc_plus4;  // Link
                end
            end
            FMT_J: begin
                next_pc = alu_res;
                wr_data = pc_plus4;
                wr_flag = 1'b1;
            end
            FMT_B:   if (taken) next_pc = alu_res;
            default: ;
        endcase
    end

    assign wr_en  = wr_flag && exec;
    assign wr_idx = dec.rd;

    // Sampled as EXECUTE closes
    a_pc_align: assert property (@(negedge exec) next_pc[0] == 1'b0);

endmodule

//--- verilog/core_top.sv
// ---------------------------------------
// Multicycle RV32I, loads/stores/CSRs absent
// ---------------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module core_top import isa_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  imem_req,
    output logic [`XLEN-1:0]      imem_addr,
    input  logic                  imem_valid,
    input  logic [`XLEN-1:0]      imem_rdata,
    output logic                  retire_valid,
    output logic [`XLEN-1:0]      retire_pc,
    output logic [`XLEN-1:0]      retire_next_pc,
    output logic                  retire_we,
    output logic [`REG_IDX_W-1:0] retire_rd,
    output logic [`XLEN-1:0]      retire_wdata
);
    inst_u                 inst;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      next_pc;
    logic                  exec;
    logic                  wr_en;
    logic [`REG_IDX_W-1:0] wr_idx;
    logic [`XLEN-1:0]      wr_data;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;

    decode_if dec_bus ();

    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .next_pc    (next_pc),
        .inst       (inst),
        .pc         (pc),
        .exec       (exec)
    );

    inst_decoder inst_decoder_inst (
        .inst (inst),
        .dec  (dec_bus.decoder)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec_bus.consumer),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit execute_unit_inst (
        .dec      (dec_bus.consumer),
        .exec     (exec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .next_pc  (next_pc),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data)
    );

    // Retire reports the EXECUTE cycle as is
    assign retire_valid   = exec;
    assign retire_pc      = pc;
    assign retire_next_pc = next_pc;
    assign retire_we      = wr_en;
    assign retire_rd      = wr_idx;
    assign retire_wdata   = wr_data;

endmodule

//--- sim/tb_core.sv
// ----------------------------------------
// Random RV32I words, 1 to 4 cycle memory latency
// Model keeps its own registers and PC
// ----------------------------------------
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_core;
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_INST = 400;
    localparam int MAX_CYCLES_PER_INST = 7;  // 4 latency, request, execute, slack

    logic                  clk;
    logic                  reset;
    logic                  imem_req;
    logic [`XLEN-1:0]      imem_addr;
    logic                  imem_valid;
    logic [`XLEN-1:0]      imem_rdata;
    logic                  retire_valid;
    logic [`XLEN-1:0]      retire_pc;
    logic [`XLEN-1:0]      retire_next_pc;
    logic                  retire_we;
    logic [`REG_IDX_W-1:0] retire_rd;
    logic [`XLEN-1:0]      retire_wdata;

    logic [`XLEN-1:0] mregs [`REG_COUNT];
    logic [`XLEN-1:0] mpc;
    integer           seed;
    int               checks [1:6];
    int               errors [1:6];
    string            test_name [1:6];

    core_top core_top_inst (
        .clk            (clk),
        .reset          (reset),
        .imem_req       (imem_req),
        .imem_addr      (imem_addr),
        .imem_valid     (imem_valid),
        .imem_rdata     (imem_rdata),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_next_pc (retire_next_pc),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_wdata   (retire_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #((RESET_CYCLES + 20 + NUM_INST * MAX_CYCLES_PER_INST) * CLK_PERIOD);
        $display("Watchdog expired before all instructions retired");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input int tid, input string name,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        checks[tid]++;
        if (act_val !== exp_val) begin
            errors[tid]++;
            $display("error: %s expected %h actual %h (test %0d)", name, exp_val, act_val, tid);
        end
    endtask

    task automatic print_test_line(input int tid);
        $display("test %0d %s: %0d checks, %0d errors", tid, test_name[tid],
                 checks[tid], errors[tid]);
    endtask

    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] x, input logic [31:0] y,
                                               input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    task automatic gen_word(output logic [31:0] w);
        int          kind;
        logic [31:0] s;
        logic [2:0]  f3;
        kind = $unsigned($random(seed)) % 16;
        w = $random(seed);
        s = $random(seed);
        f3 = w[14:12];
        if (s[2:0] == 3'b000) w[11:7] = 5'd0;
        if (s[10:8] == 3'b000) w[19:15] = 5'd0;  // Read x0 now and then
        case (kind)
            0, 1, 2, 3, 4: begin
                w[6:0] = 7'h33;
                w[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && s[4]) ? 7'h20 : 7'h00;
            end
            5, 6, 7, 8: begin
                w[6:0] = 7'h13;
                if (f3 == 3'b001) w[31:25] = 7'h00;
                else if (f3 == 3'b101) w[31:25] = s[4] ? 7'h20 : 7'h00;
            end
            9:  w[6:0] = 7'h37;
            10: w[6:0] = 7'h17;
            11: w[6:0] = 7'h6f;
            12: begin
                w[6:0] = 7'h67;
                w[14:12] = 3'b000;
            end
            13, 14: begin
                w[6:0] = 7'h63;
                if (f3[2:1] == 2'b01) w[14:12] = {2'b10, f3[0]};  // No 010/011 branches
            end
            default: w[6:0] = s[5] ? (s[6] ? 7'h73 : 7'h23) : (s[6] ? 7'h0b : 7'h03);
        endcase
    endtask

    // RV32I reference for one instruction at mpc
    task automatic model_step(input logic [31:0] w, output logic we, output logic [31:0] wdata,
                              output logic [31:0] npc, output int tid);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        taken;
        a = mregs[w[19:15]];
        b = mregs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'h000};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        we = 1'b1;
        wdata = mpc + 4;
        npc = mpc + 4;
        tid = 3;
        case (w[6:0])
            7'h33: begin
                wdata = alu_result(w[14:12], w[30], a, b, 1'b1);
                tid = 2;
            end
            7'h13: begin
                wdata = alu_result(w[14:12], w[30], a, imm_i, 1'b0);
                tid = 2;
            end
            7'h37: wdata = imm_u;
            7'h17: wdata = mpc + imm_u;
            7'h6f: npc = mpc + imm_j;
            7'h67: npc = (a + imm_i) & 32'hffff_fffe;
            7'h63: begin
                we = 1'b0;
                tid = 4;
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) npc = mpc + imm_b;
            end
            default: begin
                we = 1'b0;
                tid = 5;
            end
        endcase
        if (we && w[11:7] == 5'd0) tid = 5;
    endtask

    initial begin : stimulus
        logic [31:0] word;
        logic [31:0] wdata;
        logic [31:0] npc;
        logic        we;
        int          tid;
        int          lat;
        int          wait_cycles;
        int          total_checks;
        int          total_fail;
        seed = 32'h03de_c100;
        reset = 1'b1;
        imem_valid = 1'b0;
        imem_rdata = '0;
        test_name = '{"reset and first fetch", "alu instructions", "upper immediates and jumps",
                      "branches", "x0 and unknown opcodes", "handshake timing"};
        for (int i = 0; i < `REG_COUNT; i++) mregs[i] = '0;
        for (int t = 1; t <= 6; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        mpc = `RESET_PC;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value(1, "imem_req", 32'd0, 32'(imem_req));
            check_value(1, "retire_valid", 32'd0, 32'(retire_valid));
        end
        @(posedge clk);
        reset <= 1'b0;
        wait_cycles = 0;
        @(negedge clk);
        while (!imem_req && wait_cycles < 8) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!imem_req) begin
            checks[1]++;
            errors[1]++;
            $display("No instruction request appeared after reset was released");
        end
        check_value(1, "imem_addr", `RESET_PC, imem_addr);
        print_test_line(1);

        for (int n = 0; n < NUM_INST; n++) begin
            gen_word(word);
            lat = 1 + $unsigned($random(seed)) % 4;
            model_step(word, we, wdata, npc, tid);
            for (int k = 0; k < lat; k++) begin
                @(posedge clk);
                if (k == lat - 1) begin
                    imem_valid <= 1'b1;
                    imem_rdata <= word;
                end
                @(negedge clk);
                check_value(6, "imem_req", 32'd0, 32'(imem_req));
                check_value(6, "retire_valid", 32'd0, 32'(retire_valid));
            end
            @(posedge clk);
            imem_valid <= 1'b0;
            imem_rdata <= $random(seed);  // Junk once the strobe drops
            @(negedge clk);
            check_value(6, "retire_valid", 32'd1, 32'(retire_valid));
            check_value(tid, "retire_pc", mpc, retire_pc);
            check_value(tid, "retire_next_pc", npc, retire_next_pc);
            check_value(tid, "retire_we", 32'(we), 32'(retire_we));
            if (we) begin
                check_value(tid, "retire_rd", 32'(word[11:7]), 32'(retire_rd));
                check_value(tid, "retire_wdata", wdata, retire_wdata);
            end
            if (we && word[11:7] != 5'd0) mregs[word[11:7]] = wdata;
            mpc = npc;
            @(negedge clk);
            check_value(6, "retire_valid", 32'd0, 32'(retire_valid));
            check_value(6, "imem_req", 32'd1, 32'(imem_req));
            check_value(tid, "imem_addr", npc, imem_addr);
        end

        total_checks = 0;
        total_fail = 0;
        for (int t = 1; t <= 6; t++) begin
            if (t > 1) print_test_line(t);
            total_checks += checks[t];
            total_fail += errors[t];
        end
        $display("checks passed %0d, failed %0d", total_checks - total_fail, total_fail);
        if (total_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/decode_if.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/core_top.sv
sim/tb_core.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f build.f \
    -Mdir obj_dir -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
